//--- common/dmaTransAckPkg.sv
////////////////////////////////////////////////////////////////////////////
// DMA transfer acknowledge shared definitions
// Byte address type, descriptor address operation codes and the default
// widths that the top level hands down to its submodules
////////////////////////////////////////////////////////////////////////////
package dmaTransAckPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////
    // Byte address on the AXI side
    typedef logic [31:0] addr_t;

    // Address operation from the descriptor
    typedef enum logic [1:0]
    {
        // On the source side no data is moved at all
        OP_NONE  = 2'd0,
        // Only this one advances the address
        OP_INCR  = 2'd1,
        OP_FIXED = 2'd2,
        OP_RSVD  = 2'd3
    } addrOp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Default widths
    ////////////////////////////////////////////////////////////////////////////
    // Internal descriptor number
    localparam int DEF_NUM_INT_BDS_WIDTH = 2;

    // Byte count of a whole descriptor
    localparam int DEF_MAX_TRAN_SIZE_WIDTH = 23;

    // Byte count of one AXI burst, 4 KB max
    localparam int DEF_MAX_AXI_TRAN_SIZE_WIDTH = 13;

endpackage

//--- common/tranDscrptrIf.sv
////////////////////////////////////////////////////////////////////////////
// Queued descriptor fields
// Carries the operation held in the read and write transaction queues to
// the acknowledge controller and the operation update datapath
////////////////////////////////////////////////////////////////////////////
interface tranDscrptrIf
    import dmaTransAckPkg::*;
#(
    parameter int NUM_INT_BDS_WIDTH   = DEF_NUM_INT_BDS_WIDTH,
    parameter int MAX_TRAN_SIZE_WIDTH = DEF_MAX_TRAN_SIZE_WIDTH
)
();

    // Operation fields
    addrOp_t                        srcOp;
    addrOp_t                        dstOp;
    addr_t                          srcAddr;
    addr_t                          dstAddr;
    logic [MAX_TRAN_SIZE_WIDTH-1:0] numOfBytes;
    logic                           extDscrptr;

    // Chaining fields
    logic                           chain;
    logic                           extDscrptrNxt;
    logic [NUM_INT_BDS_WIDTH-1:0]   nxtIntDscrptrNum;

    // Operation update side
    modport dpath (input srcOp, dstOp, srcAddr, dstAddr, numOfBytes, extDscrptr);

    // Sequencer side, only the chaining information
    modport ctrl (input chain, extDscrptrNxt, nxtIntDscrptrNum);

endinterface

//--- hw/transAck/transAckCtrl.sv
////////////////////////////////////////////////////////////////////////////
// Transfer acknowledge controller
// Admits an arbiter request once both transaction queues have room, waits
// for the read control to be ready, pulses the acknowledge and, at the end
// of a descriptor chained to an internal one, holds a fetch request until
// the descriptor source mux takes it
////////////////////////////////////////////////////////////////////////////
module transAckCtrl
    import dmaTransAckPkg::*;
#(
    parameter int NUM_INT_BDS_WIDTH = DEF_NUM_INT_BDS_WIDTH
)
(
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         doTrans,
    input  logic                         spaceWrTranQueue,
    input  logic                         spaceRdTranQueue,
    input  logic                         rdyToAck,
    input  logic                         intFetchAck,
    input  logic                         opDone,
    tranDscrptrIf.ctrl                   dscrptr,
    output logic                         loadOp,
    output logic                         transAck,
    output logic                         fetchIntDscrptr,
    output logic [NUM_INT_BDS_WIDTH-1:0] intDscrptrNum
);

    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_TRANS_RDY,
        WAIT_INT_DSCRPTR_FETCH
    } state_t;

    state_t state;
    state_t nextState;
    logic   startFetch;

    // Ready report accepted, datapath loads the new operation
    assign loadOp = (state == WAIT_TRANS_RDY) && rdyToAck;

    // Last piece of a descriptor whose successor is internal
    assign startFetch = loadOp && opDone && dscrptr.chain && !dscrptr.extDscrptrNxt;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        case (state)
            IDLE:
            begin
                // Hold off while either queue is full
                if (doTrans && spaceWrTranQueue && spaceRdTranQueue)
                begin
                    nextState = WAIT_TRANS_RDY;
                end
            end
            WAIT_TRANS_RDY:
            begin
                if (startFetch)
                begin
                    nextState = WAIT_INT_DSCRPTR_FETCH;
                end
                else if (loadOp)
                begin
                    nextState = IDLE;
                end
            end
            WAIT_INT_DSCRPTR_FETCH:
            begin
                if (intFetchAck)
                begin
                    nextState = IDLE;
                end
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered state and outputs
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state           <= IDLE;
            transAck        <= 1'b0;
            fetchIntDscrptr <= 1'b0;
        end
        else
        begin
            state           <= nextState;
            // One cycle pulse, the state leaves WAIT_TRANS_RDY on loadOp
            transAck        <= loadOp;
            fetchIntDscrptr <= (nextState == WAIT_INT_DSCRPTR_FETCH);
        end
    end

    // Descriptor number stays put for the whole fetch request
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            intDscrptrNum <= '0;
        end
        else if (startFetch)
        begin
            intDscrptrNum <= dscrptr.nxtIntDscrptrNum;
        end
    end

endmodule

//--- hw/transAck/opUpdate.sv
////////////////////////////////////////////////////////////////////////////
// Operation update datapath
// Computes the remaining byte count and the next source and destination
// addresses after one AXI burst, registers them with the data-valid flag
// on loadOp, and flags when the burst finishes the descriptor
////////////////////////////////////////////////////////////////////////////
module opUpdate
    import dmaTransAckPkg::*;
#(
    parameter int MAX_TRAN_SIZE_WIDTH     = DEF_MAX_TRAN_SIZE_WIDTH,
    parameter int MAX_AXI_TRAN_SIZE_WIDTH = DEF_MAX_AXI_TRAN_SIZE_WIDTH
)
(
    input  logic                               clock,
    input  logic                               resetn,
    input  logic                               loadOp,
    input  logic                               extDataValidRd,
    input  logic [MAX_AXI_TRAN_SIZE_WIDTH-1:0] srcAXINumOfBytes,
    tranDscrptrIf.dpath                        dscrptr,
    output logic                               opDone,
    output logic                               extDataValid,
    output logic [MAX_TRAN_SIZE_WIDTH-1:0]     newNumOfBytes,
    output addr_t                              newSrcAddr,
    output addr_t                              newDstAddr
);

    typedef logic [MAX_TRAN_SIZE_WIDTH-1:0] count_t;

    count_t burstBytes;
    addr_t  burstStep;
    logic   noOpSrc;
    logic   skipTransfer;
    count_t nextNumOfBytes;
    addr_t  nextSrcAddr;
    addr_t  nextDstAddr;

    // Burst length widened to count and address width
    assign burstBytes = count_t'(srcAXINumOfBytes);
    assign burstStep  = addr_t'(srcAXINumOfBytes);

    assign noOpSrc = (dscrptr.srcOp == OP_NONE);

    // External descriptor fetched without its data-ready bit, nothing moved
    assign skipTransfer = dscrptr.extDscrptr && !extDataValidRd;

    // Descriptor ends on a no-op or when this burst moves the rest
    assign opDone = noOpSrc || (!skipTransfer && (dscrptr.numOfBytes == burstBytes));

    ////////////////////////////////////////////////////////////////////////////
    // Updated operation
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextNumOfBytes = dscrptr.numOfBytes;
        nextSrcAddr    = dscrptr.srcAddr;
        nextDstAddr    = dscrptr.dstAddr;
        if (noOpSrc)
        begin
            nextNumOfBytes = '0;
        end
        else if (!skipTransfer)
        begin
            nextNumOfBytes = dscrptr.numOfBytes - burstBytes;
            // Fixed and reserved operations keep the address
            if (dscrptr.srcOp == OP_INCR)
            begin
                nextSrcAddr = dscrptr.srcAddr + burstStep;
            end
            if (dscrptr.dstOp == OP_INCR)
            begin
                nextDstAddr = dscrptr.dstAddr + burstStep;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers, held between acknowledges
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            extDataValid  <= 1'b0;
            newNumOfBytes <= '0;
            newSrcAddr    <= '0;
            newDstAddr    <= '0;
        end
        else if (loadOp)
        begin
            extDataValid  <= extDataValidRd;
            newNumOfBytes <= nextNumOfBytes;
            newSrcAddr    <= nextSrcAddr;
            newDstAddr    <= nextDstAddr;
        end
    end

endmodule

//--- hw/transAck/dmaTransAck.sv
////////////////////////////////////////////////////////////////////////////
// DMA transfer acknowledge stage
// Acknowledges arbiter transfer requests with the updated operation and
// requests the next internal descriptor when a chained one completes
////////////////////////////////////////////////////////////////////////////
module dmaTransAck
    import dmaTransAckPkg::*;
#(
    parameter int NUM_INT_BDS_WIDTH       = DEF_NUM_INT_BDS_WIDTH,
    parameter int MAX_TRAN_SIZE_WIDTH     = DEF_MAX_TRAN_SIZE_WIDTH,
    parameter int MAX_AXI_TRAN_SIZE_WIDTH = DEF_MAX_AXI_TRAN_SIZE_WIDTH
)
(
    input  logic                               clock,
    input  logic                               resetn,
    // Arbiter and descriptor source mux
    input  logic                               doTrans,
    input  logic                               intFetchAck,
    // Read transfer control
    input  logic                               rdyToAck,
    input  logic                               extDataValid_DMARdTranCtrl,
    input  logic [MAX_AXI_TRAN_SIZE_WIDTH-1:0] srcAXINumOfBytes,
    // Write transaction queue
    input  logic                               spaceWrTranQueue,
    input  addrOp_t                            dstOp,
    input  addr_t                              dstAddr_WrTranQueue,
    // Read transaction queue
    input  logic                               spaceRdTranQueue,
    input  logic                               chain,
    input  logic                               extDscrptrNxt,
    input  logic                               extDscrptr,
    input  addrOp_t                            srcOp,
    input  addr_t                              srcAddr_RdTranQueue,
    input  logic [MAX_TRAN_SIZE_WIDTH-1:0]     numOfBytes_RdTranQueue,
    input  logic [NUM_INT_BDS_WIDTH-1:0]       nxtIntDscrptrNum_rdTranQueue,
    // Back to the arbiter
    output logic                               transAck,
    output logic                               extDataValid,
    output logic [MAX_TRAN_SIZE_WIDTH-1:0]     newNumOfBytes,
    output addr_t                              newSrcAddr,
    output addr_t                              newDstAddr,
    // To the descriptor source mux
    output logic                               fetchIntDscrptr,
    output logic [NUM_INT_BDS_WIDTH-1:0]       intDscrptrNum
);

    logic loadOp;
    logic opDone;

    tranDscrptrIf #(
        .NUM_INT_BDS_WIDTH   (NUM_INT_BDS_WIDTH),
        .MAX_TRAN_SIZE_WIDTH (MAX_TRAN_SIZE_WIDTH)
    ) dscrptrBus ();

    // Queue heads onto the descriptor bus
    assign dscrptrBus.srcOp            = srcOp;
    assign dscrptrBus.dstOp            = dstOp;
    assign dscrptrBus.srcAddr          = srcAddr_RdTranQueue;
    assign dscrptrBus.dstAddr          = dstAddr_WrTranQueue;
    assign dscrptrBus.numOfBytes       = numOfBytes_RdTranQueue;
    assign dscrptrBus.extDscrptr       = extDscrptr;
    assign dscrptrBus.chain            = chain;
    assign dscrptrBus.extDscrptrNxt    = extDscrptrNxt;
    assign dscrptrBus.nxtIntDscrptrNum = nxtIntDscrptrNum_rdTranQueue;

    transAckCtrl #(
        .NUM_INT_BDS_WIDTH (NUM_INT_BDS_WIDTH)
    ) transAckCtrlInst (
        .clock            (clock),
        .resetn           (resetn),
        .doTrans          (doTrans),
        .spaceWrTranQueue (spaceWrTranQueue),
        .spaceRdTranQueue (spaceRdTranQueue),
        .rdyToAck         (rdyToAck),
        .intFetchAck      (intFetchAck),
        .opDone           (opDone),
        .dscrptr          (dscrptrBus.ctrl),
        .loadOp           (loadOp),
        .transAck         (transAck),
        .fetchIntDscrptr  (fetchIntDscrptr),
        .intDscrptrNum    (intDscrptrNum)
    );

    opUpdate #(
        .MAX_TRAN_SIZE_WIDTH     (MAX_TRAN_SIZE_WIDTH),
        .MAX_AXI_TRAN_SIZE_WIDTH (MAX_AXI_TRAN_SIZE_WIDTH)
    ) opUpdateInst (
        .clock            (clock),
        .resetn           (resetn),
        .loadOp           (loadOp),
        .extDataValidRd   (extDataValid_DMARdTranCtrl),
        .srcAXINumOfBytes (srcAXINumOfBytes),
        .dscrptr          (dscrptrBus.dpath),
        .opDone           (opDone),
        .extDataValid     (extDataValid),
        .newNumOfBytes    (newNumOfBytes),
        .newSrcAddr       (newSrcAddr),
        .newDstAddr       (newDstAddr)
    );

endmodule

//--- verification/dmaTransAck_assertions.sv
////////////////////////////////////////////////////////////////////////////
// Transfer acknowledge controller checks
// Acknowledge pulse width and the internal descriptor fetch request
////////////////////////////////////////////////////////////////////////////
module dmaTransAck_assertions
    import dmaTransAckPkg::*;
#(
    parameter int NUM_INT_BDS_WIDTH = DEF_NUM_INT_BDS_WIDTH
)
(
    input logic                         clock,
    input logic                         resetn,
    input logic                         transAck,
    input logic                         intFetchAck,
    input logic                         fetchIntDscrptr,
    input logic [NUM_INT_BDS_WIDTH-1:0] intDscrptrNum
);

    int failCount = 0;

    task automatic noteFailure(input string what);
        $error("%s", what);
        failCount++;
    endtask

    // One cycle acknowledge
    ackPulse: assert property (@(posedge clock) disable iff (!resetn) transAck |=> !transAck)
        else noteFailure("transAck high in two consecutive cycles");

    // Request drops exactly one cycle after intFetchAck
    fetchHeld: assert property (@(posedge clock) disable iff (!resetn)
        fetchIntDscrptr |=> fetchIntDscrptr == !$past(intFetchAck))
        else noteFailure("fetchIntDscrptr not held until the cycle after intFetchAck");

    numStable: assert property (@(posedge clock) disable iff (!resetn)
        fetchIntDscrptr |=> !fetchIntDscrptr || $stable(intDscrptrNum))
        else noteFailure("intDscrptrNum changed during a fetch request");

endmodule

bind transAckCtrl dmaTransAck_assertions #(.NUM_INT_BDS_WIDTH(NUM_INT_BDS_WIDTH))
    ctrlChecks (.*);

//--- verification/dmaTransAckTb.sv
////////////////////////////////////////////////////////////////////////////
// DMA transfer acknowledge testbench
// Random and directed descriptor operations checked against a model of the
// updated operation, with a responder for internal descriptor fetches
////////////////////////////////////////////////////////////////////////////
module dmaTransAckTb
    import dmaTransAckPkg::*;
();

    typedef logic [DEF_MAX_TRAN_SIZE_WIDTH-1:0]     count_t;
    typedef logic [DEF_MAX_AXI_TRAN_SIZE_WIDTH-1:0] burst_t;
    typedef logic [DEF_NUM_INT_BDS_WIDTH-1:0]       bdNum_t;

    // 58 operations, none longer than 40 cycles, plus reset
    localparam int CYCLE_LIMIT = 40 * 58 + 16;

    logic    clock;
    logic    resetn;
    logic    doTrans, intFetchAck, rdyToAck, extDataValid_DMARdTranCtrl;
    logic    spaceWrTranQueue, spaceRdTranQueue, chain, extDscrptrNxt, extDscrptr;
    addrOp_t srcOp, dstOp;
    addr_t   srcAddr_RdTranQueue, dstAddr_WrTranQueue;
    burst_t  srcAXINumOfBytes;
    count_t  numOfBytes_RdTranQueue;
    bdNum_t  nxtIntDscrptrNum_rdTranQueue;
    logic    transAck, extDataValid, fetchIntDscrptr;
    count_t  newNumOfBytes;
    addr_t   newSrcAddr, newDstAddr;
    bdNum_t  intDscrptrNum;

    // Expected response of the operation in flight
    string   testName;
    count_t  expNum;
    addr_t   expSrc, expDst;
    logic    expDv, expFetch;
    bdNum_t  expIntNum;
    int      errors = 0;
    int      ackCount = 0;
    logic    testsDone = 1'b0;

    dmaTransAck dmaTransAck_inst (.*);

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic nextCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic checkValue(input string what, input logic [127:0] expected, actual);
        assert (actual == expected)
        else
        begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of one burst
    ////////////////////////////////////////////////////////////////////////////
    function automatic void predictOp(input addrOp_t sOp, dOp, input addr_t sA, dA,
        input count_t num, input burst_t burst, input logic ext, dv, ch, extN,
        output count_t eNum, output addr_t eSrc, eDst, output logic eDv, eFetch);
        logic skip;
        logic done;
        // External descriptor whose data never became ready
        skip   = ext && !dv;
        eDv    = dv;
        eNum   = (sOp == OP_NONE) ? '0 : (skip ? num : num - count_t'(burst));
        eSrc   = (sOp == OP_INCR && !skip) ? sA + addr_t'(burst) : sA;
        eDst   = (sOp != OP_NONE && dOp == OP_INCR && !skip) ? dA + addr_t'(burst) : dA;
        done   = (sOp == OP_NONE) || (!skip && num == count_t'(burst));
        eFetch = done && ch && !extN;
    endfunction

    // Descriptor source mux, answers after 0 to 5 cycles
    task automatic respondFetch();
        repeat ($urandom_range(0, 5)) nextCycle();
        intFetchAck = 1'b1;
        nextCycle();
        intFetchAck = 1'b0;
        checkValue("fetchIntDscrptr after intFetchAck", 0, fetchIntDscrptr);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One arbiter request from queue load to acknowledge
    ////////////////////////////////////////////////////////////////////////////
    task automatic runOp(input string name, input addrOp_t sOp, dOp, input count_t num,
        input burst_t burst, input logic ext, dv, ch, extN, input int hold);
        int startAcks;
        nextCycle();
        startAcks                    = ackCount;
        testName                     = name;
        srcOp                        = sOp;
        dstOp                        = dOp;
        srcAddr_RdTranQueue          = $urandom;
        dstAddr_WrTranQueue          = $urandom;
        numOfBytes_RdTranQueue       = num;
        srcAXINumOfBytes             = burst;
        // Next number always differs from the one held now
        nxtIntDscrptrNum_rdTranQueue = intDscrptrNum + bdNum_t'($urandom_range(1, 3));
        expIntNum                    = nxtIntDscrptrNum_rdTranQueue;
        {extDscrptr, extDataValid_DMARdTranCtrl, chain, extDscrptrNxt} = {ext, dv, ch, extN};
        predictOp(sOp, dOp, srcAddr_RdTranQueue, dstAddr_WrTranQueue, num, burst,
                  ext, dv, ch, extN, expNum, expSrc, expDst, expDv, expFetch);
        doTrans = 1'b1;
        // Read queue full for the first hold cycles
        spaceRdTranQueue = (hold == 0);
        // Ready report already up, only the full queue holds the request off
        rdyToAck = (hold != 0);
        repeat (hold) nextCycle();
        checkValue("acknowledges while queue full", 0, ackCount - startAcks);
        spaceRdTranQueue = 1'b1;
        if (hold == 0)
            repeat ($urandom_range(0, 3)) nextCycle();
        rdyToAck = 1'b1;
        do
        begin
            nextCycle();
        end
        while (!transAck);
        doTrans  = 1'b0;
        rdyToAck = 1'b0;
        if (expFetch)
            respondFetch();
        repeat (2) nextCycle();
        checkValue("acknowledge count", 1, ackCount - startAcks);
    endtask

    // Every acknowledge against the model
    always @(negedge clock)
    begin
        if (transAck)
        begin
            ackCount++;
            checkValue("newNumOfBytes", expNum, newNumOfBytes);
            checkValue("newSrcAddr", expSrc, newSrcAddr);
            checkValue("newDstAddr", expDst, newDstAddr);
            checkValue("extDataValid", expDv, extDataValid);
            checkValue("fetchIntDscrptr", expFetch, fetchIntDscrptr);
            if (expFetch)
                checkValue("intDscrptrNum", expIntNum, intDscrptrNum);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        burst_t burst;
        void'($urandom(63663));
        resetn = 1'b0;
        {doTrans, intFetchAck, rdyToAck, extDataValid_DMARdTranCtrl} = '0;
        {spaceWrTranQueue, spaceRdTranQueue, chain, extDscrptrNxt, extDscrptr} = '0;
        {srcAddr_RdTranQueue, dstAddr_WrTranQueue, srcAXINumOfBytes} = '0;
        {numOfBytes_RdTranQueue, nxtIntDscrptrNum_rdTranQueue} = '0;
        srcOp    = OP_NONE;
        dstOp    = OP_NONE;
        testName = "reset";
        repeat (16) @(posedge clock);
        #2;
        resetn           = 1'b1;
        spaceWrTranQueue = 1'b1;
        checkValue("transAck", 0, transAck);
        checkValue("fetchIntDscrptr", 0, fetchIntDscrptr);
        checkValue("outputs", 0, {extDataValid, newNumOfBytes, newSrcAddr, newDstAddr,
                                  intDscrptrNum});

        // Internal descriptors with more left than one burst
        for (int i = 0; i < 50; i++)
        begin
            burst = burst_t'($urandom_range(1, 4096));
            runOp("internal", addrOp_t'($urandom_range(1, 2)), addrOp_t'($urandom_range(1, 2)),
                  count_t'(burst) + count_t'($urandom_range(1, 1 << 20)), burst, 1'b0,
                  1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                  1'($urandom_range(0, 1)), 0);
        end

        runOp("chained final", OP_INCR, OP_INCR, 256, 256, 1'b0, 1'b0, 1'b1, 1'b0, 0);
        runOp("chained external next", OP_FIXED, OP_INCR, 64, 64, 1'b0, 1'b0, 1'b1, 1'b1, 0);
        runOp("unchained final", OP_INCR, OP_FIXED, 4096, 4096, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        runOp("external not ready", OP_INCR, OP_INCR, 512, 512, 1'b1, 1'b0, 1'b1, 1'b0, 0);
        runOp("external ready", OP_INCR, OP_FIXED, 900, 300, 1'b1, 1'b1, 1'b0, 1'b0, 0);
        runOp("no-op source", OP_NONE, OP_INCR, 700, 100, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        runOp("no-op chained", OP_NONE, OP_FIXED, 700, 100, 1'b0, 1'b0, 1'b1, 1'b0, 0);
        runOp("back-pressure", OP_INCR, OP_INCR, 8192, 2048, 1'b0, 1'b0, 1'b0, 1'b0, 10);
        testsDone = 1'b1;
    end

    // Run limit and closing report
    initial
    begin
        int cycles;
        int assertFails;
        cycles = 0;
        while (!testsDone && cycles < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycles++;
        end
        if (!testsDone)
        begin
            $display("timeout: transAck never arrived");
            errors++;
        end
        assertFails = dmaTransAck_inst.transAckCtrlInst.ctrlChecks.failCount;
        $display("errors: %0d, assertion failures: %0d", errors, assertFails);
        if (errors == 0 && assertFails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- all.f
common/dmaTransAckPkg.sv
common/tranDscrptrIf.sv
hw/transAck/transAckCtrl.sv
hw/transAck/opUpdate.sv
hw/transAck/dmaTransAck.sv
verification/dmaTransAck_assertions.sv
verification/dmaTransAckTb.sv
